// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vicii_fetch
FILELIST  ?= vicii_fetch.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= SIMULATION PASSED

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep "^$(PASS_MSG)$$" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: include/vicii_defines.svh
`ifndef VICII_DEFINES_SVH
`define VICII_DEFINES_SVH

// sprite engine size
`define NUM_SPRITES 8

// character cells fetched on one line
`define CHAR_SLOTS 40

// dot clock cycles in one half-cycle slot
`define CLKS_PER_SLOT 4

// half-cycle slots in one raster line
`define SLOTS_PER_LINE 128

// short frame so a few frames fit in simulation
`define LINES_PER_FRAME 16

`endif

// File: verif/tb_vicii_fetch.sv
`timescale 1ns/100ps

`include "vicii_defines.svh"

module tb_vicii_fetch import vicii_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    // four frames of 16 lines at 512 clocks plus margin
    localparam int CYCLE_LIMIT = 4 * `LINES_PER_FRAME * 512 + 1024;

    logic        clk_dot4x;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [5:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic [11:0] dbi;
    cycle_type_t cycle_type;
    logic [6:0]  slot;
    logic [3:0]  raster;
    logic        pixel_valid;
    logic        pixel_on;
    logic [3:0]  pixel_color;
    logic [7:0]  pixel_char;

    // data bus contents indexed by {raster, slot}
    logic [11:0] dbus_table [0:2047];
    logic [31:0] lfsr;

    // reference model state
    logic        den_m;
    logic [2:0]  ysc_m;
    logic [7:0]  spr_en_m;
    logic [3:0]  bg_m;
    logic        idle_m;
    logic [7:0]  ptr_m [0:7];
    logic [23:0] sdata_m [0:7];
    int          sdata_cnt [0:7];
    logic [11:0] cache_q [$];
    logic [19:0] grp_q [$];
    logic [19:0] cur_grp;
    int          pix_idx;
    logic        have_prev;
    logic [6:0]  prev_slot;
    logic [3:0]  prev_raster;
    logic        exp_valid;
    logic [6:0]  exp_slot;
    logic [3:0]  exp_raster;

    int errors;
    int checks;
    int cycles;
    int dot_cnt;

    vicii_fetch_top uut (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .dbi         (dbi),
        .cycle_type  (cycle_type),
        .slot        (slot),
        .raster      (raster),
        .pixel_valid (pixel_valid),
        .pixel_on    (pixel_on),
        .pixel_color (pixel_color),
        .pixel_char  (pixel_char)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;
    end

    // galois step for taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
        errors++;
    endtask

    function automatic cycle_type_t expected_type(input logic [6:0] s, input logic [3:0] r);
        logic bad;
        bad = den_m && (r[2:0] == ysc_m);
        if (s < 7'd32) begin
            if (s[1:0] == 2'd0) begin
                expected_type = VIC_LP;
            end else if (!spr_en_m[s[4:2]]) begin
                expected_type = VIC_IDLE_SLOT;
            end else if (s[1:0] == 2'd1) begin
                expected_type = VIC_HS1;
            end else if (s[1:0] == 2'd2) begin
                expected_type = VIC_LS2;
            end else begin
                expected_type = VIC_HS3;
            end
        end else if (s < 7'd112) begin
            expected_type = s[0] ? VIC_LG : (bad ? VIC_HRC : VIC_HRX);
        end else begin
            expected_type = VIC_IDLE_SLOT;
        end
    endfunction

    // apply the access rules for a slot that has just ended
    task automatic complete_slot(input logic [6:0] s, input logic [3:0] r);
        logic [11:0] d;
        logic [11:0] oldest;
        logic [6:0]  k;
        logic [2:0]  n;
        d = dbus_table[{r, s}];
        n = s[4:2];
        k = (s - 7'd32) >> 1;
        if (s < 7'd32) begin
            if (s[1:0] == 2'd0) begin
                ptr_m[n] = spr_en_m[n] ? d[7:0] : 8'hff;
            end else if (spr_en_m[n]) begin
                sdata_m[n] = {sdata_m[n][15:0], d[7:0]};
                sdata_cnt[n]++;
            end
        end else if (s < 7'd112) begin
            if (!s[0]) begin
                oldest = cache_q.pop_front();
                if (den_m && (r[2:0] == ysc_m)) begin
                    cache_q.push_back(k < 7'd3 ? {d[11:8], 8'hff} : d);
                end else begin
                    cache_q.push_back(oldest);
                end
            end else begin
                grp_q.push_back({d[7:0], idle_m ? 12'h000 : cache_q[$]});
            end
        end
        if (s == 7'd0 && r == 4'd0) begin
            idle_m = !den_m;
        end
    endtask

    task automatic check_pixel();
        logic       exp_on;
        logic [3:0] exp_col;
        if (pix_idx == 0) begin
            if (grp_q.size() == 0) begin
                $display("[ERROR] %0t pixel group started without a g-access", $time);
                errors++;
                cur_grp = 20'h0;
            end else begin
                cur_grp = grp_q.pop_front();
            end
        end
        exp_on  = cur_grp[19 - pix_idx];
        exp_col = exp_on ? cur_grp[11:8] : bg_m;
        checks++;
        assert (pixel_on === exp_on) else report_mismatch("pixel_on", 32'(exp_on), 32'(pixel_on));
        assert (pixel_color === exp_col)
            else report_mismatch("pixel_color", 32'(exp_col), 32'(pixel_color));
        assert (pixel_char === cur_grp[7:0])
            else report_mismatch("pixel_char", 32'(cur_grp[7:0]), 32'(pixel_char));
        pix_idx = (pix_idx + 1) % 8;
    endtask

    // data bus model with slot bookkeeping and pixel checks
    always @(negedge clk_dot4x) begin
        if (rst) begin
            have_prev = 1'b0;
            pix_idx   = 0;
        end else begin
            // a group is due while one is queued or still being shifted out
            exp_valid  = (grp_q.size() != 0) || (pix_idx != 0);
            exp_slot   = 7'((dot_cnt / `CLKS_PER_SLOT) % `SLOTS_PER_LINE);
            exp_raster = 4'((dot_cnt / (`CLKS_PER_SLOT * `SLOTS_PER_LINE)) % `LINES_PER_FRAME);
            assert (slot === exp_slot) else report_mismatch("slot", 32'(exp_slot), 32'(slot));
            assert (raster === exp_raster)
                else report_mismatch("raster", 32'(exp_raster), 32'(raster));
            assert (pixel_valid === exp_valid)
                else report_mismatch("pixel_valid", 32'(exp_valid), 32'(pixel_valid));
            if (have_prev && slot != prev_slot) begin
                complete_slot(prev_slot, prev_raster);
            end
            prev_slot   = slot;
            prev_raster = raster;
            have_prev   = 1'b1;
            assert (cycle_type == expected_type(slot, raster))
                else report_mismatch("cycle_type", 32'(expected_type(slot, raster)),
                                     32'(cycle_type));
            if (pixel_valid) begin
                check_pixel();
            end
        end
        dbi <= dbus_table[{raster, slot}];
    end

    assert property (@(posedge clk_dot4x) disable iff (rst) pixel_on |-> pixel_valid)
        else begin
            $display("[ERROR] %0t pixel_on raised outside a pixel group", $time);
            errors++;
        end

    // dot clocks since reset release
    always @(posedge clk_dot4x) begin
        if (rst) begin
            dot_cnt = 0;
        end else begin
            dot_cnt++;
        end
    end

    always @(posedge clk_dot4x) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic apb_write(input logic [5:0] addr, input logic [31:0] data);
        @(negedge clk_dot4x);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk_dot4x);
        penable = 1'b1;
        @(posedge clk_dot4x);
        case (addr)
            6'd0: begin
                den_m = data[4];
                ysc_m = data[2:0];
            end
            6'd1: spr_en_m = data[7:0];
            6'd2: bg_m = data[3:0];
            default: ;
        endcase
        @(negedge clk_dot4x);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_check_read(input logic [5:0] addr, input logic [31:0] exp);
        @(negedge clk_dot4x);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk_dot4x);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        checks++;
        assert (pready === 1'b1) else report_mismatch("pready", 32'd1, 32'(pready));
        assert (prdata === exp) else report_mismatch($sformatf("prdata[%0d]", addr), exp, prdata);
        @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_slot(input logic [6:0] s);
        do @(negedge clk_dot4x); while (slot != s);
    endtask

    task automatic wait_frame_start();
        do @(negedge clk_dot4x); while (!(raster == 4'd0 && slot == 7'd0));
        do @(negedge clk_dot4x); while (slot == 7'd0);
    endtask

    task automatic check_sprites();
        wait_slot(7'd113);
        for (int i = 0; i < 8; i++) begin
            apb_check_read(6'd8 + 6'(i), {24'd0, ptr_m[i]});
        end
        wait_slot(7'd113);
        for (int i = 0; i < 8; i++) begin
            // only words filled by three s-accesses are known
            if (sdata_cnt[i] >= 3) begin
                apb_check_read(6'd16 + 6'(i), {8'd0, sdata_m[i]});
            end
        end
    endtask

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 6'd0;
        pwdata  = 32'd0;
        dbi     = 12'd0;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        den_m    = 1'b0;
        ysc_m    = 3'd0;
        spr_en_m = 8'd0;
        bg_m     = 4'd0;
        idle_m   = 1'b1;
        pix_idx  = 0;
        have_prev = 1'b0;
        lfsr = 32'hc39a_0fb7;
        for (int a = 0; a < 2048; a++) begin
            for (int b = 0; b < 12; b++) begin
                dbus_table[a][b] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
        end
        for (int i = 0; i < 8; i++) begin
            ptr_m[i]     = 8'd0;
            sdata_m[i]   = 24'd0;
            sdata_cnt[i] = 0;
        end
        for (int i = 0; i < `CHAR_SLOTS; i++) begin
            cache_q.push_back(12'h0ff);
        end

        repeat (2) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        rst = 1'b0;

        // pointers read before their first p-access
        for (int i = 0; i < 8; i++) begin
            apb_check_read(6'd8 + 6'(i), 32'd0);
        end

        wait_slot(7'd113);
        apb_write(6'd0, 32'h0000_0013);
        apb_write(6'd1, 32'h0000_00a5);
        apb_write(6'd2, 32'h0000_0006);
        apb_check_read(6'd0, 32'h0000_0013);
        apb_check_read(6'd1, 32'h0000_00a5);
        apb_check_read(6'd2, 32'h0000_0006);
        apb_check_read(6'd5, 32'd0);
        apb_check_read(6'd40, 32'd0);

        // frame 0 stays idle and frame 1 displays
        wait_frame_start();
        wait_frame_start();
        check_sprites();

        // disabled sprites keep their data words
        wait_slot(7'd113);
        apb_write(6'd1, 32'h0000_005a);
        wait_slot(7'd40);
        check_sprites();

        wait_slot(7'd113);
        apb_write(6'd0, 32'h0000_0003);
        wait_frame_start();
        repeat (4) wait_slot(7'd120);

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/bus_access.sv
`timescale 1ns/100ps

`include "vicii_defines.svh"

module bus_access import vicii_pkg::*; (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     phi_phase_start_dav,
    input  cycle_type_t              cycle_type,
    input  logic [11:0]              dbi,
    input  logic                     idle,
    input  logic [2:0]               sprite_cnt,
    input  logic                     aec,
    input  logic [`NUM_SPRITES-1:0]  sprite_dma,
    output logic [7:0]               sprite_ptr [0:`NUM_SPRITES-1],
    output logic [7:0]               pixels_read,
    output logic [11:0]              char_read,
    output logic                     g_valid,
    output logic [23:0]              sprite_pixels [0:`NUM_SPRITES-1]
);

    // char_next is the 40th cell of the line buffer
    localparam int CACHE_LAST = `CHAR_SLOTS - 2;

    logic [11:0] char_buf [0:CACHE_LAST];
    logic [11:0] char_next;
    logic        c_access;
    logic        g_access;

    assign c_access = phi_phase_start_dav &&
                      (cycle_type inside {VIC_HRC, VIC_HGC, VIC_HRX, VIC_HGI});
    assign g_access = phi_phase_start_dav && (cycle_type == VIC_LG);

    // c-access, new cell on a badline, otherwise rotate the oldest cell back in
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            char_next <= 12'h0ff;
            for (int i = 0; i <= CACHE_LAST; i++) begin
                char_buf[i] <= 12'h0ff;
            end
        end else if (c_access) begin
            case (cycle_type)
                VIC_HRC, VIC_HGC: begin
                    if (!aec) begin
                        char_next <= dbi;
                    end else begin
                        // bus not yet handed over, only colour is valid
                        char_next <= {dbi[11:8], 8'hff};
                    end
                end
                default: char_next <= char_buf[CACHE_LAST];
            endcase
            for (int i = CACHE_LAST; i > 0; i--) begin
                char_buf[i] <= char_buf[i-1];
            end
            char_buf[0] <= char_next;
        end
    end

    // g-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixels_read <= 8'd0;
            char_read   <= 12'd0;
            g_valid     <= 1'b0;
        end else begin
            g_valid <= g_access;
            if (g_access) begin
                pixels_read <= dbi[7:0];
                char_read   <= idle ? 12'd0 : char_next;
            end
        end
    end

    // p-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < `NUM_SPRITES; i++) begin
                sprite_ptr[i] <= 8'd0;
            end
        end else if (phi_phase_start_dav && cycle_type == VIC_LP) begin
            if (sprite_dma[sprite_cnt]) begin
                sprite_ptr[sprite_cnt] <= dbi[7:0];
            end else begin
                sprite_ptr[sprite_cnt] <= 8'hff;
            end
        end
    end

    // s-access, three bytes shifted in per line
    always_ff @(posedge clk_dot4x) begin
        if (phi_phase_start_dav && sprite_dma[sprite_cnt]) begin
            case (cycle_type)
                VIC_HS1, VIC_LS2, VIC_HS3: begin
                    sprite_pixels[sprite_cnt] <= {sprite_pixels[sprite_cnt][15:0], dbi[7:0]};
                end
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/cycle_sequencer.sv
`timescale 1ns/100ps

`include "vicii_defines.svh"

module cycle_sequencer import vicii_pkg::*; (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     den,
    input  logic [2:0]               yscroll,
    input  logic [`NUM_SPRITES-1:0]  spr_en,
    output logic                     phi_phase_start_dav,
    output cycle_type_t              cycle_type,
    output logic [2:0]               sprite_cnt,
    output logic                     aec,
    output logic                     idle,
    output logic [6:0]               slot,
    output logic [3:0]               raster
);

    localparam int DIV_W     = $clog2(`CLKS_PER_SLOT);
    localparam int LAST_SLOT = `SLOTS_PER_LINE - 1;
    localparam int LAST_LINE = `LINES_PER_FRAME - 1;
    // four slots per sprite, then c/g pairs for every cell
    localparam int SPR_END   = 4 * `NUM_SPRITES;
    localparam int CHR_END   = SPR_END + 2 * `CHAR_SLOTS;
    // c-accesses made while the CPU still owns the bus
    localparam int AEC_CYCLES = 3;

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       c_cnt;
    logic             c_slot;
    logic             badline;

    // strobe is registered one count early so it is high for the last clock of a slot
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            div_cnt             <= '0;
            phi_phase_start_dav <= 1'b0;
        end else begin
            if (div_cnt == DIV_W'(`CLKS_PER_SLOT - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            phi_phase_start_dav <= (div_cnt == DIV_W'(`CLKS_PER_SLOT - 2));
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            slot   <= 7'd0;
            raster <= 4'd0;
        end else if (phi_phase_start_dav) begin
            if (slot == 7'(LAST_SLOT)) begin
                slot <= 7'd0;
                if (raster == 4'(LAST_LINE)) begin
                    raster <= 4'd0;
                end else begin
                    raster <= raster + 4'd1;
                end
            end else begin
                slot <= slot + 7'd1;
            end
        end
    end

    assign badline = den && (raster[2:0] == yscroll);

    // c-slots seen so far on this line, saturating
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            c_cnt <= 2'd0;
            idle  <= 1'b1;
        end else if (phi_phase_start_dav) begin
            if (slot == 7'(LAST_SLOT)) begin
                c_cnt <= 2'd0;
            end else if (c_slot && c_cnt != 2'(AEC_CYCLES)) begin
                c_cnt <= c_cnt + 2'd1;
            end
            // display enable only takes effect per frame
            if (slot == 7'd0 && raster == 4'd0) begin
                idle <= !den;
            end
        end
    end

    assign aec = badline && c_slot && (c_cnt < 2'(AEC_CYCLES));

    always_comb begin
        c_slot     = 1'b0;
        sprite_cnt = 3'd0;
        cycle_type = VIC_IDLE_SLOT;
        if (slot < 7'(SPR_END)) begin
            sprite_cnt = slot[4:2];
            // s-accesses of a sprite without DMA become idle slots
            case (slot[1:0])
                2'd0: cycle_type = VIC_LP;
                2'd1: cycle_type = spr_en[slot[4:2]] ? VIC_HS1 : VIC_IDLE_SLOT;
                2'd2: cycle_type = spr_en[slot[4:2]] ? VIC_LS2 : VIC_IDLE_SLOT;
                default: cycle_type = spr_en[slot[4:2]] ? VIC_HS3 : VIC_IDLE_SLOT;
            endcase
        end else if (slot < 7'(CHR_END)) begin
            if (!slot[0]) begin
                c_slot     = 1'b1;
                cycle_type = badline ? VIC_HRC : VIC_HRX;
            end else begin
                cycle_type = VIC_LG;
            end
        end
    end

endmodule

// File: verilog/pixel_serializer.sv
`timescale 1ns/100ps

module pixel_serializer (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  logic        g_valid,
    input  logic [7:0]  pixels_read,
    input  logic [11:0] char_read,
    input  logic [3:0]  bg_color,
    output logic        pixel_valid,
    output logic        pixel_on,
    output logic [3:0]  pixel_color,
    output logic [7:0]  pixel_char
);

    logic [7:0] shift_q;
    logic [2:0] cnt_q;
    logic [3:0] fg_color_q;
    logic [7:0] char_q;

    // group control
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_valid <= 1'b0;
            cnt_q       <= 3'd0;
        end else if (g_valid) begin
            pixel_valid <= 1'b1;
            cnt_q       <= 3'd7;
        end else if (pixel_valid) begin
            if (cnt_q == 3'd0) begin
                pixel_valid <= 1'b0;
            end else begin
                cnt_q <= cnt_q - 3'd1;
            end
        end
    end

    // byte and attributes, MSB goes out first
    always_ff @(posedge clk_dot4x) begin
        if (g_valid) begin
            shift_q    <= pixels_read;
            fg_color_q <= char_read[11:8];
            char_q     <= char_read[7:0];
        end else if (pixel_valid) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign pixel_on    = pixel_valid && shift_q[7];
    // background shows through clear pixels
    assign pixel_color = pixel_on ? fg_color_q : bg_color;
    assign pixel_char  = char_q;

endmodule

// File: verilog/vicii_apb_regs.sv
`timescale 1ns/100ps

`include "vicii_defines.svh"

module vicii_apb_regs import vicii_pkg::*; (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [5:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     den,
    output logic [2:0]               yscroll,
    output logic [`NUM_SPRITES-1:0]  spr_en,
    output logic [3:0]               bg_color,
    input  logic [7:0]               sprite_ptr [0:`NUM_SPRITES-1],
    input  logic [23:0]              sprite_pixels [0:`NUM_SPRITES-1]
);

    apb_reg_t reg_addr;
    logic     wr_en;

    assign reg_addr = apb_reg_t'(paddr);

    // no wait states
    assign pready = 1'b1;

    // writes land in the access phase
    assign wr_en = psel && penable && pwrite;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            den      <= 1'b0;
            yscroll  <= 3'd0;
            spr_en   <= '0;
            bg_color <= 4'd0;
        end else if (wr_en) begin
            case (reg_addr)
                REG_CTRL: begin
                    den     <= pwdata[4];
                    yscroll <= pwdata[2:0];
                end
                REG_SPR_EN:   spr_en   <= pwdata[`NUM_SPRITES-1:0];
                REG_BG_COLOR: bg_color <= pwdata[3:0];
                default: ;
            endcase
        end
    end

    // read mux, sprite banks indexed by the low address bits
    always_comb begin
        prdata = 32'd0;
        if (psel && !pwrite) begin
            if (reg_addr == REG_CTRL) begin
                prdata = {27'd0, den, 1'b0, yscroll};
            end else if (reg_addr == REG_SPR_EN) begin
                prdata = {{(32-`NUM_SPRITES){1'b0}}, spr_en};
            end else if (reg_addr == REG_BG_COLOR) begin
                prdata = {28'd0, bg_color};
            end else if (paddr >= REG_SPR_PTR0 && paddr <= REG_SPR_PTR7) begin
                prdata = {24'd0, sprite_ptr[paddr[2:0]]};
            end else if (paddr >= REG_SPR_DATA0 && paddr <= REG_SPR_DATA7) begin
                prdata = {8'd0, sprite_pixels[paddr[2:0]]};
            end
        end
    end

endmodule

// File: verilog/vicii_fetch_top.sv
`timescale 1ns/100ps

`include "vicii_defines.svh"

module vicii_fetch_top import vicii_pkg::*; (
    input  logic        clk_dot4x,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [5:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    input  logic [11:0] dbi,
    output cycle_type_t cycle_type,
    output logic [6:0]  slot,
    output logic [3:0]  raster,
    output logic        pixel_valid,
    output logic        pixel_on,
    output logic [3:0]  pixel_color,
    output logic [7:0]  pixel_char
);

    logic                     den;
    logic [2:0]               yscroll;
    logic [`NUM_SPRITES-1:0]  spr_en;
    logic [3:0]               bg_color;
    logic [7:0]               sprite_ptr [0:`NUM_SPRITES-1];
    logic [23:0]              sprite_pixels [0:`NUM_SPRITES-1];
    logic                     phi_phase_start_dav;
    logic [2:0]               sprite_cnt;
    logic                     aec;
    logic                     idle;
    logic [7:0]               pixels_read;
    logic [11:0]              char_read;
    logic                     g_valid;

    vicii_apb_regs u_regs (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .den           (den),
        .yscroll       (yscroll),
        .spr_en        (spr_en),
        .bg_color      (bg_color),
        .sprite_ptr    (sprite_ptr),
        .sprite_pixels (sprite_pixels)
    );

    cycle_sequencer u_seq (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .den                 (den),
        .yscroll             (yscroll),
        .spr_en              (spr_en),
        .phi_phase_start_dav (phi_phase_start_dav),
        .cycle_type          (cycle_type),
        .sprite_cnt          (sprite_cnt),
        .aec                 (aec),
        .idle                (idle),
        .slot                (slot),
        .raster              (raster)
    );

    bus_access u_bus (
        .clk_dot4x           (clk_dot4x),
        .rst                 (rst),
        .phi_phase_start_dav (phi_phase_start_dav),
        .cycle_type          (cycle_type),
        .dbi                 (dbi),
        .idle                (idle),
        .sprite_cnt          (sprite_cnt),
        .aec                 (aec),
        .sprite_dma          (spr_en),
        .sprite_ptr          (sprite_ptr),
        .pixels_read         (pixels_read),
        .char_read           (char_read),
        .g_valid             (g_valid),
        .sprite_pixels       (sprite_pixels)
    );

    pixel_serializer u_ser (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .g_valid     (g_valid),
        .pixels_read (pixels_read),
        .char_read   (char_read),
        .bg_color    (bg_color),
        .pixel_valid (pixel_valid),
        .pixel_on    (pixel_on),
        .pixel_color (pixel_color),
        .pixel_char  (pixel_char)
    );

endmodule

// File: verilog/vicii_pkg.sv
package vicii_pkg;

    // access performed in a half-cycle slot
    typedef enum logic [3:0] {
        VIC_LP,
        VIC_HS1,
        VIC_LS2,
        VIC_HS3,
        VIC_HRC,
        VIC_HRX,
        VIC_HGC,
        VIC_HGI,
        VIC_LG,
        VIC_IDLE_SLOT
    } cycle_type_t;

    // APB word addresses, sprite banks aligned to 8 words
    typedef enum logic [5:0] {
        REG_CTRL      = 6'd0,
        REG_SPR_EN    = 6'd1,
        REG_BG_COLOR  = 6'd2,
        REG_SPR_PTR0  = 6'd8,
        REG_SPR_PTR1  = 6'd9,
        REG_SPR_PTR2  = 6'd10,
        REG_SPR_PTR3  = 6'd11,
        REG_SPR_PTR4  = 6'd12,
        REG_SPR_PTR5  = 6'd13,
        REG_SPR_PTR6  = 6'd14,
        REG_SPR_PTR7  = 6'd15,
        REG_SPR_DATA0 = 6'd16,
        REG_SPR_DATA1 = 6'd17,
        REG_SPR_DATA2 = 6'd18,
        REG_SPR_DATA3 = 6'd19,
        REG_SPR_DATA4 = 6'd20,
        REG_SPR_DATA5 = 6'd21,
        REG_SPR_DATA6 = 6'd22,
        REG_SPR_DATA7 = 6'd23
    } apb_reg_t;

endpackage

// File: vicii_fetch.f
+incdir+include
verilog/vicii_pkg.sv
verilog/vicii_apb_regs.sv
verilog/cycle_sequencer.sv
verilog/bus_access.sv
verilog/pixel_serializer.sv
verilog/vicii_fetch_top.sv
verif/tb_vicii_fetch.sv
